// File: verilog/bus_pkg.sv
package bus_pkg;

    // word address, data and byte-select widths of the system bus
    localparam int ADR_W = 30;
    localparam int DAT_W = 32;
    localparam int SEL_W = DAT_W / 8;

    // arbiter ownership states
    localparam logic [1:0] ARB_IDLE = 2'd0;
    localparam logic [1:0] ARB_A    = 2'd1;
    localparam logic [1:0] ARB_B    = 2'd2;

endpackage : bus_pkg

// File: verilog/map_pkg.sv
package map_pkg;

    // top address bits pick the region
    localparam int REGION_W = 9;
    localparam int OFFSET_W = bus_pkg::ADR_W - REGION_W;

    localparam logic [REGION_W-1:0] REGION_RAM = 9'd0;
    localparam logic [REGION_W-1:0] REGION_SYS = 9'd1;

    // 256 words, upper offset bits alias
    localparam int RAM_AW = 8;

    localparam int SYS_IDX_W = 3;
    localparam int UPPER_W   = bus_pkg::ADR_W - SYS_IDX_W;

    localparam logic [SYS_IDX_W-1:0] REG_ID      = 3'd0;
    localparam logic [SYS_IDX_W-1:0] REG_SCRATCH = 3'd1;
    localparam logic [SYS_IDX_W-1:0] REG_BUSERR  = 3'd2;
    localparam logic [SYS_IDX_W-1:0] REG_UPTIME  = 3'd3;
    localparam logic [SYS_IDX_W-1:0] REG_IRQ     = 3'd4;

    localparam logic [bus_pkg::DAT_W-1:0] SYS_ID_VALUE = 32'h20191028;

    // one word address, seen as region/offset or as register index
    typedef union packed {
        struct packed {
            logic [REGION_W-1:0] region;
            logic [OFFSET_W-1:0] offset;
        } rgn;
        struct packed {
            logic [UPPER_W-1:0]   upper;
            logic [SYS_IDX_W-1:0] idx;
        } sys;
    } wb_addr_u;

endpackage : map_pkg

// File: verilog/wb_bus_if.sv
`timescale 1ns/1ps

interface wb_bus_if;

    logic                      cyc;
    logic                      stb;
    logic                      we;
    map_pkg::wb_addr_u         adr;
    logic [bus_pkg::DAT_W-1:0] dat_w;
    logic [bus_pkg::SEL_W-1:0] sel;

    // slave answer, ack or err one cycle after acceptance
    logic                      ack;
    logic                      stall;
    logic                      err;
    logic [bus_pkg::DAT_W-1:0] dat_r;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  ack, stall, err, dat_r
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output ack, stall, err, dat_r
    );

endinterface : wb_bus_if

// File: verilog/wb_pri_arbiter.sv
`timescale 1ns/1ps

module wb_pri_arbiter (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_a_cyc,
    input  logic                      i_a_stb,
    input  logic                      i_a_we,
    input  logic [bus_pkg::ADR_W-1:0] i_a_adr,
    input  logic [bus_pkg::DAT_W-1:0] i_a_dat,
    input  logic [bus_pkg::SEL_W-1:0] i_a_sel,
    output logic                      o_a_ack,
    output logic                      o_a_stall,
    output logic                      o_a_err,
    input  logic                      i_b_cyc,
    input  logic                      i_b_stb,
    input  logic                      i_b_we,
    input  logic [bus_pkg::ADR_W-1:0] i_b_adr,
    input  logic [bus_pkg::DAT_W-1:0] i_b_dat,
    input  logic [bus_pkg::SEL_W-1:0] i_b_sel,
    output logic                      o_b_ack,
    output logic                      o_b_stall,
    output logic                      o_b_err,
    wb_bus_if.master                  m_bus
);
    import bus_pkg::*;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       own_a;
    logic       own_b;

    // owner releases only by dropping cyc, a wins from idle
    always_comb begin
        state_nxt = state;
        case (state)
            ARB_A: begin
                if (!i_a_cyc) begin
                    state_nxt = i_b_cyc ? ARB_B : ARB_IDLE;
                end
            end
            ARB_B: begin
                if (!i_b_cyc) begin
                    state_nxt = i_a_cyc ? ARB_A : ARB_IDLE;
                end
            end
            default: begin
                if (i_a_cyc) begin
                    state_nxt = ARB_A;
                end else if (i_b_cyc) begin
                    state_nxt = ARB_B;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign own_a = (state == ARB_A);
    assign own_b = (state == ARB_B);

    // owner's request straight through
    assign m_bus.cyc   = (own_a & i_a_cyc) | (own_b & i_b_cyc);
    assign m_bus.stb   = (own_a & i_a_stb) | (own_b & i_b_stb);
    assign m_bus.we    = own_b ? i_b_we  : i_a_we;
    assign m_bus.adr   = own_b ? i_b_adr : i_a_adr;
    assign m_bus.dat_w = own_b ? i_b_dat : i_a_dat;
    assign m_bus.sel   = own_b ? i_b_sel : i_a_sel;

    // non-owner only ever sees stall
    assign o_a_ack   = own_a & m_bus.ack;
    assign o_a_err   = own_a & m_bus.err;
    assign o_a_stall = ~own_a | m_bus.stall;
    assign o_b_ack   = own_b & m_bus.ack;
    assign o_b_err   = own_b & m_bus.err;
    assign o_b_stall = ~own_b | m_bus.stall;

    a_single_ack : assert property (
        @(posedge i_clk) disable iff (!i_arst_n) !(o_a_ack && o_b_ack)
    );

endmodule : wb_pri_arbiter

// File: verilog/wb_addr_decode.sv
`timescale 1ns/1ps

module wb_addr_decode (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    wb_bus_if.slave                   s_bus,
    output logic                      o_ram_stb,
    output logic                      o_sys_stb,
    output logic                      o_we,
    output logic [bus_pkg::DAT_W-1:0] o_wdat,
    output logic [bus_pkg::SEL_W-1:0] o_sel,
    output map_pkg::wb_addr_u         o_addr,
    input  logic [bus_pkg::DAT_W-1:0] i_ram_dat,
    input  logic [bus_pkg::DAT_W-1:0] i_sys_dat,
    output logic                      o_err_pulse
);
    import map_pkg::*;

    logic accept;
    logic ram_hit;
    logic sys_hit;
    logic ack_q;
    logic err_q;
    logic sel_ram_q;

    // slaves never stall, so every strobe is taken
    assign accept  = s_bus.cyc & s_bus.stb;
    assign ram_hit = (s_bus.adr.rgn.region == REGION_RAM);
    assign sys_hit = (s_bus.adr.rgn.region == REGION_SYS);

    assign o_ram_stb = accept & ram_hit;
    assign o_sys_stb = accept & sys_hit;
    assign o_we      = s_bus.we;
    assign o_wdat    = s_bus.dat_w;
    assign o_sel     = s_bus.sel;
    assign o_addr    = s_bus.adr;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            sel_ram_q <= 1'b0;
        end else begin
            ack_q     <= accept & (ram_hit | sys_hit);
            // unmapped region
            err_q     <= accept & ~ram_hit & ~sys_hit;
            sel_ram_q <= ram_hit;
        end
    end

    assign s_bus.stall = 1'b0;
    assign s_bus.ack   = ack_q;
    assign s_bus.err   = err_q;
    assign o_err_pulse = err_q;

    // read data only alongside ack
    assign s_bus.dat_r = !ack_q    ? '0 :
                         sel_ram_q ? i_ram_dat : i_sys_dat;

    a_ack_err_excl : assert property (
        @(posedge i_clk) disable iff (!i_arst_n) !(s_bus.ack && s_bus.err)
    );

endmodule : wb_addr_decode

// File: verilog/uptime_counter.sv
`timescale 1ns/1ps

module uptime_counter (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    output logic [bus_pkg::DAT_W-1:0] o_count
);
    import bus_pkg::*;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_count <= '0;
        end else begin
            o_count[DAT_W-2:0] <= o_count[DAT_W-2:0] + 1'b1;
            // top bit latches on the first carry out
            o_count[DAT_W-1]   <= o_count[DAT_W-1] | (&o_count[DAT_W-2:0]);
        end
    end

    a_top_sticky : assert property (
        @(posedge i_clk) disable iff (!i_arst_n) o_count[DAT_W-1] |=> o_count[DAT_W-1]
    );

endmodule : uptime_counter

// File: verilog/sys_regs.sv
`timescale 1ns/1ps

module sys_regs (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_stb,
    input  logic                      i_we,
    input  map_pkg::wb_addr_u         i_addr,
    input  logic [bus_pkg::DAT_W-1:0] i_wdat,
    input  logic                      i_err_pulse,
    input  logic [bus_pkg::DAT_W-1:0] i_uptime,
    output logic [bus_pkg::DAT_W-1:0] o_rdat,
    output logic                      o_irq
);
    import bus_pkg::*;
    import map_pkg::*;

    logic [DAT_W-1:0] scratch;
    logic [ADR_W-1:0] bus_err_adr;
    logic             irq_flag;
    wb_addr_u         addr_q;

    // err answers the request from one cycle back
    always_ff @(posedge i_clk) begin
        addr_q <= i_addr;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            scratch     <= '0;
            bus_err_adr <= '0;
            irq_flag    <= 1'b0;
        end else begin
            if (i_stb && i_we) begin
                case (i_addr.sys.idx)
                    REG_SCRATCH: scratch  <= i_wdat;
                    REG_IRQ:     irq_flag <= i_wdat[0];
                    default:     ;
                endcase
            end
            if (i_err_pulse) begin
                bus_err_adr <= addr_q;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (i_addr.sys.idx)
                REG_ID:      o_rdat <= SYS_ID_VALUE;
                REG_SCRATCH: o_rdat <= scratch;
                // word address back to a byte address
                REG_BUSERR:  o_rdat <= {bus_err_adr, 2'b00};
                REG_UPTIME:  o_rdat <= i_uptime;
                REG_IRQ:     o_rdat <= {{(DAT_W-1){1'b0}}, irq_flag};
                default:     o_rdat <= '0;
            endcase
        end
    end

    assign o_irq = irq_flag;

endmodule : sys_regs

// File: verilog/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic                      i_clk,
    input  logic                      i_stb,
    input  logic                      i_we,
    input  map_pkg::wb_addr_u         i_addr,
    input  logic [bus_pkg::DAT_W-1:0] i_wdat,
    input  logic [bus_pkg::SEL_W-1:0] i_sel,
    output logic [bus_pkg::DAT_W-1:0] o_rdat
);
    import bus_pkg::*;
    import map_pkg::*;

    logic [DAT_W-1:0]  mem [2**RAM_AW];
    logic [RAM_AW-1:0] word_idx;

    // upper offset bits ignored
    assign word_idx = i_addr.rgn.offset[RAM_AW-1:0];

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            if (i_we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (i_sel[b]) begin
                        mem[word_idx][8*b +: 8] <= i_wdat[8*b +: 8];
                    end
                end
            end
            // old word on a write
            o_rdat <= mem[word_idx];
        end
    end

endmodule : word_ram

// File: verilog/wb_fabric_top.sv
`timescale 1ns/1ps

module wb_fabric_top (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_a_cyc,
    input  logic                      i_a_stb,
    input  logic                      i_a_we,
    input  logic [bus_pkg::ADR_W-1:0] i_a_adr,
    input  logic [bus_pkg::DAT_W-1:0] i_a_dat,
    input  logic [bus_pkg::SEL_W-1:0] i_a_sel,
    output logic                      o_a_ack,
    output logic                      o_a_stall,
    output logic                      o_a_err,
    input  logic                      i_b_cyc,
    input  logic                      i_b_stb,
    input  logic                      i_b_we,
    input  logic [bus_pkg::ADR_W-1:0] i_b_adr,
    input  logic [bus_pkg::DAT_W-1:0] i_b_dat,
    input  logic [bus_pkg::SEL_W-1:0] i_b_sel,
    output logic                      o_b_ack,
    output logic                      o_b_stall,
    output logic                      o_b_err,
    output logic [bus_pkg::DAT_W-1:0] o_rd_dat,
    output logic                      o_irq
);
    import bus_pkg::*;
    import map_pkg::*;

    logic             ram_stb;
    logic             sys_stb;
    logic             slv_we;
    logic [DAT_W-1:0] slv_wdat;
    logic [SEL_W-1:0] slv_sel;
    wb_addr_u         slv_addr;
    logic [DAT_W-1:0] ram_dat;
    logic [DAT_W-1:0] sys_dat;
    logic             err_pulse;
    logic [DAT_W-1:0] uptime;

    wb_bus_if fabric_bus ();

    wb_pri_arbiter wb_pri_arbiter_inst (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_a_cyc   (i_a_cyc),
        .i_a_stb   (i_a_stb),
        .i_a_we    (i_a_we),
        .i_a_adr   (i_a_adr),
        .i_a_dat   (i_a_dat),
        .i_a_sel   (i_a_sel),
        .o_a_ack   (o_a_ack),
        .o_a_stall (o_a_stall),
        .o_a_err   (o_a_err),
        .i_b_cyc   (i_b_cyc),
        .i_b_stb   (i_b_stb),
        .i_b_we    (i_b_we),
        .i_b_adr   (i_b_adr),
        .i_b_dat   (i_b_dat),
        .i_b_sel   (i_b_sel),
        .o_b_ack   (o_b_ack),
        .o_b_stall (o_b_stall),
        .o_b_err   (o_b_err),
        .m_bus     (fabric_bus.master)
    );

    wb_addr_decode wb_addr_decode_inst (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .s_bus       (fabric_bus.slave),
        .o_ram_stb   (ram_stb),
        .o_sys_stb   (sys_stb),
        .o_we        (slv_we),
        .o_wdat      (slv_wdat),
        .o_sel       (slv_sel),
        .o_addr      (slv_addr),
        .i_ram_dat   (ram_dat),
        .i_sys_dat   (sys_dat),
        .o_err_pulse (err_pulse)
    );

    // one read data bus shared by both masters
    assign o_rd_dat = fabric_bus.dat_r;

    uptime_counter uptime_counter_inst (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .o_count  (uptime)
    );

    sys_regs sys_regs_inst (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_stb       (sys_stb),
        .i_we        (slv_we),
        .i_addr      (slv_addr),
        .i_wdat      (slv_wdat),
        .i_err_pulse (err_pulse),
        .i_uptime    (uptime),
        .o_rdat      (sys_dat),
        .o_irq       (o_irq)
    );

    word_ram word_ram_inst (
        .i_clk  (i_clk),
        .i_stb  (ram_stb),
        .i_we   (slv_we),
        .i_addr (slv_addr),
        .i_wdat (slv_wdat),
        .i_sel  (slv_sel),
        .o_rdat (ram_dat)
    );

endmodule : wb_fabric_top

// File: test/fabric_checks.svh
`ifndef FABRIC_CHECKS_SVH
`define FABRIC_CHECKS_SVH

task automatic end_in_failure();
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic stop_on_error(input string msg);
    $display("%s", msg);
    end_in_failure();
endtask

task automatic check_val(
    input string             name,
    input logic [DAT_W-1:0]  exp,
    input logic [DAT_W-1:0]  act
);
    assert (act === exp) else begin
        $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
        end_in_failure();
    end
endtask

// accepted request gets exactly one answer in the next cycle
chk_answer_a : assert property (@(posedge clk) disable iff (!arst_n)
    (m_cyc[0] && m_stb[0] && !m_stall[0]) |=> (m_ack[0] ^ m_err[0]))
    else stop_on_error("master a request did not get exactly one answer");
chk_answer_b : assert property (@(posedge clk) disable iff (!arst_n)
    (m_cyc[1] && m_stb[1] && !m_stall[1]) |=> (m_ack[1] ^ m_err[1]))
    else stop_on_error("master b request did not get exactly one answer");

// no answer without an accepted request
chk_quiet_a : assert property (@(posedge clk) disable iff (!arst_n)
    !(m_cyc[0] && m_stb[0] && !m_stall[0]) |=> !(m_ack[0] || m_err[0]))
    else stop_on_error("master a got an answer it did not ask for");
chk_quiet_b : assert property (@(posedge clk) disable iff (!arst_n)
    !(m_cyc[1] && m_stb[1] && !m_stall[1]) |=> !(m_ack[1] || m_err[1]))
    else stop_on_error("master b got an answer it did not ask for");

// only one owner at a time
chk_one_owner : assert property (@(posedge clk) disable iff (!arst_n)
    !(!m_stall[0] && !m_stall[1]))
    else stop_on_error("both masters were unstalled in the same cycle");
chk_acks_apart : assert property (@(posedge clk) disable iff (!arst_n)
    !(m_ack[0] && m_ack[1]))
    else stop_on_error("both masters received ack in the same cycle");

// read data bus is zero outside ack
chk_rd_idle : assert property (@(posedge clk) disable iff (!arst_n)
    !(m_ack[0] || m_ack[1]) |-> (rd_dat == '0))
    else stop_on_error("read data was not zero in a cycle without ack");

`endif

// File: test/tb_fabric.sv
`timescale 1ns/1ps

module tb_fabric;
    import bus_pkg::*;
    import map_pkg::*;

    // bound on bus operations for the watchdog
    localparam int N_OPS     = 44;
    localparam int OP_CYCLES = 20;
    localparam bit M_A = 1'b0;
    localparam bit M_B = 1'b1;
    localparam bit RD  = 1'b0;
    localparam bit WR  = 1'b1;

    logic             clk = 1'b0;
    logic             arst_n;
    logic [1:0]       m_cyc;
    logic [1:0]       m_stb;
    logic [1:0]       m_we;
    logic [ADR_W-1:0] m_adr [2];
    logic [DAT_W-1:0] m_dat [2];
    logic [SEL_W-1:0] m_sel [2];
    logic [1:0]       m_ack;
    logic [1:0]       m_stall;
    logic [1:0]       m_err;
    logic [DAT_W-1:0] rd_dat;
    logic             irq;

    // request lists and answers with one row per master
    logic [ADR_W-1:0] req_adr [2][16];
    logic [DAT_W-1:0] req_dat [2][16];
    logic [SEL_W-1:0] req_sel [2][16];
    bit               req_we  [2][16];
    logic [3:0]       req_n   [2];
    logic [DAT_W-1:0] rsp_dat [2][16];
    bit               rsp_err [2][16];
    int               acc_cyc [2][16];
    int               start_cyc [2];
    int               done_cyc  [2];
    int               cycle_cnt = 0;

    // reference model
    logic [DAT_W-1:0] ram_model [256];
    logic [DAT_W-1:0] scratch_model;

    `include "fabric_checks.svh"

    wb_fabric_top wb_fabric_top_inst (
        .i_clk     (clk),
        .i_arst_n  (arst_n),
        .i_a_cyc   (m_cyc[0]),
        .i_a_stb   (m_stb[0]),
        .i_a_we    (m_we[0]),
        .i_a_adr   (m_adr[0]),
        .i_a_dat   (m_dat[0]),
        .i_a_sel   (m_sel[0]),
        .o_a_ack   (m_ack[0]),
        .o_a_stall (m_stall[0]),
        .o_a_err   (m_err[0]),
        .i_b_cyc   (m_cyc[1]),
        .i_b_stb   (m_stb[1]),
        .i_b_we    (m_we[1]),
        .i_b_adr   (m_adr[1]),
        .i_b_dat   (m_dat[1]),
        .i_b_sel   (m_sel[1]),
        .o_b_ack   (m_ack[1]),
        .o_b_stall (m_stall[1]),
        .o_b_err   (m_err[1]),
        .o_rd_dat  (rd_dat),
        .o_irq     (irq)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [ADR_W-1:0] ram_adr(input logic [RAM_AW-1:0] idx);
        // random upper offset bits exercise aliasing
        return {REGION_RAM, 13'($urandom), idx};
    endfunction

    function automatic logic [ADR_W-1:0] sys_adr(input logic [SYS_IDX_W-1:0] idx);
        return {REGION_SYS, 18'($urandom), idx};
    endfunction

    function automatic logic [DAT_W-1:0] merge_bytes(
        input logic [DAT_W-1:0] old_w,
        input logic [DAT_W-1:0] new_w,
        input logic [SEL_W-1:0] sel
    );
        logic [DAT_W-1:0] res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic clear_reqs();
        req_n[0] = '0;
        req_n[1] = '0;
    endtask

    task automatic add_req(
        input bit               m,
        input bit               we,
        input logic [ADR_W-1:0] adr,
        input logic [DAT_W-1:0] dat,
        input logic [SEL_W-1:0] sel
    );
        req_we[m][req_n[m]]  = we;
        req_adr[m][req_n[m]] = adr;
        req_dat[m][req_n[m]] = dat;
        req_sel[m][req_n[m]] = sel;
        req_n[m] = req_n[m] + 4'd1;
    endtask

    // issues the list back to back with stb held high until all are taken
    task automatic run_burst(input bit m);
        logic [3:0] issued;
        logic [3:0] answered;
        issued = '0;
        answered = '0;
        start_cyc[m] = cycle_cnt;
        m_cyc[m] = 1'b1;
        while (answered < req_n[m]) begin
            m_stb[m] = (issued < req_n[m]);
            if (issued < req_n[m]) begin
                m_we[m]  = req_we[m][issued];
                m_adr[m] = req_adr[m][issued];
                m_dat[m] = req_dat[m][issued];
                m_sel[m] = req_sel[m][issued];
            end
            // outputs are settled mid cycle
            @(negedge clk);
            if (m_ack[m] || m_err[m]) begin
                rsp_dat[m][answered] = rd_dat;
                rsp_err[m][answered] = m_err[m];
                done_cyc[m] = cycle_cnt;
                answered = answered + 4'd1;
            end
            if (m_stb[m] && !m_stall[m]) begin
                acc_cyc[m][issued] = cycle_cnt;
                issued = issued + 4'd1;
            end
            @(posedge clk);
            #1;
        end
        m_stb[m] = 1'b0;
        m_cyc[m] = 1'b0;
        // idle cycle lets the arbiter drop back to idle
        @(posedge clk);
        #1;
    endtask

    task automatic do_single(
        input bit               m,
        input bit               we,
        input logic [ADR_W-1:0] adr,
        input logic [DAT_W-1:0] dat
    );
        clear_reqs();
        add_req(m, we, adr, dat, 4'hf);
        run_burst(m);
    endtask

    task automatic check_answers(input bit m);
        for (int i = 0; i < req_n[m]; i++) begin
            check_val(m ? "o_b_err" : "o_a_err", 32'd0, 32'(rsp_err[m][i]));
        end
    endtask

    task automatic test_ram();
        logic [RAM_AW-1:0] idx [8];
        logic [DAT_W-1:0]  dat;
        logic [SEL_W-1:0]  sel;
        clear_reqs();
        for (int i = 0; i < 8; i++) begin
            idx[i] = RAM_AW'($urandom);
            dat = $urandom;
            add_req(M_A, WR, ram_adr(idx[i]), dat, 4'hf);
            ram_model[idx[i]] = dat;
        end
        run_burst(M_A);
        check_answers(M_A);
        // partial writes over the same words
        clear_reqs();
        for (int i = 0; i < 8; i++) begin
            dat = $urandom;
            sel = SEL_W'($urandom);
            add_req(M_A, WR, ram_adr(idx[i]), dat, sel);
            ram_model[idx[i]] = merge_bytes(ram_model[idx[i]], dat, sel);
        end
        run_burst(M_A);
        check_answers(M_A);
        clear_reqs();
        for (int i = 0; i < 8; i++) begin
            add_req(M_A, RD, ram_adr(idx[i]), '0, 4'hf);
        end
        run_burst(M_A);
        check_answers(M_A);
        for (int i = 0; i < 8; i++) begin
            check_val("o_rd_dat", ram_model[idx[i]], rsp_dat[M_A][i]);
        end
        for (int i = 0; i < 2; i++) begin
            do_single(M_B, RD, ram_adr(idx[i]), '0);
            check_answers(M_B);
            check_val("o_rd_dat", ram_model[idx[i]], rsp_dat[M_B][0]);
        end
    endtask

    task automatic test_sys();
        do_single(M_A, RD, sys_adr(REG_ID), '0);
        check_answers(M_A);
        check_val("o_rd_dat", SYS_ID_VALUE, rsp_dat[M_A][0]);
        scratch_model = $urandom;
        do_single(M_B, WR, sys_adr(REG_SCRATCH), scratch_model);
        do_single(M_B, RD, sys_adr(REG_SCRATCH), '0);
        check_answers(M_B);
        check_val("o_rd_dat", scratch_model, rsp_dat[M_B][0]);
        // irq flag set then cleared
        do_single(M_A, WR, sys_adr(REG_IRQ), 32'h1);
        check_val("o_irq", 32'd1, 32'(irq));
        do_single(M_A, RD, sys_adr(REG_IRQ), '0);
        check_val("o_rd_dat", 32'd1, rsp_dat[M_A][0]);
        do_single(M_A, WR, sys_adr(REG_IRQ), 32'h0);
        check_val("o_irq", 32'd0, 32'(irq));
        do_single(M_A, RD, sys_adr(REG_IRQ), '0);
        check_val("o_rd_dat", 32'd0, rsp_dat[M_A][0]);
    endtask

    task automatic test_unmapped();
        logic [REGION_W-1:0] region;
        logic [ADR_W-1:0]    bad_adr;
        region = REGION_W'(2 + $urandom % 510);
        bad_adr = {region, OFFSET_W'($urandom)};
        do_single(M_A, 1'($urandom), bad_adr, $urandom);
        check_val("o_a_err", 32'd1, 32'(rsp_err[M_A][0]));
        check_val("o_rd_dat", 32'd0, rsp_dat[M_A][0]);
        do_single(M_B, RD, sys_adr(REG_BUSERR), '0);
        check_answers(M_B);
        check_val("o_rd_dat", 32'(bad_adr) * 32'd4, rsp_dat[M_B][0]);
    endtask

    task automatic test_uptime();
        int               gap;
        int               c0;
        logic [DAT_W-1:0] t0;
        gap = 2 + int'($urandom % 6);
        clear_reqs();
        add_req(M_B, RD, sys_adr(REG_UPTIME), '0, 4'hf);
        add_req(M_B, RD, sys_adr(REG_UPTIME), '0, 4'hf);
        run_burst(M_B);
        check_val("o_rd_dat", 32'(acc_cyc[M_B][1] - acc_cyc[M_B][0]),
                  rsp_dat[M_B][1] - rsp_dat[M_B][0]);
        t0 = rsp_dat[M_B][1];
        c0 = acc_cyc[M_B][1];
        repeat (gap) @(posedge clk);
        #1;
        do_single(M_A, RD, sys_adr(REG_UPTIME), '0);
        check_val("o_rd_dat", 32'(acc_cyc[M_A][0] - c0), rsp_dat[M_A][0] - t0);
    endtask

    task automatic test_arbitration();
        clear_reqs();
        for (int i = 0; i < 4; i++) begin
            add_req(M_A, RD, sys_adr((i % 2 == 0) ? REG_SCRATCH : REG_ID), '0, 4'hf);
        end
        add_req(M_B, RD, sys_adr(REG_ID), '0, 4'hf);
        add_req(M_B, RD, sys_adr(REG_SCRATCH), '0, 4'hf);
        // both raise cyc in the same cycle from idle
        fork
            run_burst(M_A);
            run_burst(M_B);
        join
        assert (acc_cyc[M_A][0] == start_cyc[M_A] + 1) else
            stop_on_error("master a was not granted one cycle after its request");
        assert (acc_cyc[M_B][0] > done_cyc[M_A]) else
            stop_on_error("master b was served before master a released the bus");
        check_answers(M_A);
        check_answers(M_B);
        for (int i = 0; i < 4; i++) begin
            check_val("o_rd_dat", (i % 2 == 0) ? scratch_model : SYS_ID_VALUE,
                      rsp_dat[M_A][i]);
        end
        check_val("o_rd_dat", SYS_ID_VALUE, rsp_dat[M_B][0]);
        check_val("o_rd_dat", scratch_model, rsp_dat[M_B][1]);
    endtask

    initial begin
        void'($urandom(32'hbbe2));
        arst_n = 1'b0;
        m_cyc = '0;
        m_stb = '0;
        m_we = '0;
        for (int i = 0; i < 2; i++) begin
            m_adr[i] = '0;
            m_dat[i] = '0;
            m_sel[i] = '0;
        end
        clear_reqs();
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_val("o_a_ack", 32'd0, 32'(m_ack[0]));
        check_val("o_a_err", 32'd0, 32'(m_err[0]));
        check_val("o_b_ack", 32'd0, 32'(m_ack[1]));
        check_val("o_b_err", 32'd0, 32'(m_err[1]));
        check_val("o_irq", 32'd0, 32'(irq));
        test_ram();
        test_sys();
        test_unmapped();
        test_uptime();
        test_arbitration();
        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (16 + N_OPS * OP_CYCLES) @(posedge clk);
        stop_on_error("watchdog expired before the tests finished");
    end

endmodule : tb_fabric

// File: sim.f
+incdir+test
verilog/bus_pkg.sv
verilog/map_pkg.sv
verilog/wb_bus_if.sv
verilog/wb_pri_arbiter.sv
verilog/wb_addr_decode.sv
verilog/uptime_counter.sv
verilog/sys_regs.sv
verilog/word_ram.sv
verilog/wb_fabric_top.sv
test/tb_fabric.sv

// File: run.sh
#!/bin/sh
# build and run the bus fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_fabric -o sim_fabric
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_fabric > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
